/* hdl/divOpPkg.sv */
// Divide opcode definitions
// Shared by operand decode, result correction and the top level

package divOpPkg;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  // The eight M-extension divide instructions
  // The W forms work on the low 32 bits and are only legal on RV64
  typedef enum logic [2:0] {
    OP_DIV   = 3'd0,
    OP_DIVU  = 3'd1,
    OP_REM   = 3'd2,
    OP_REMU  = 3'd3,
    OP_DIVW  = 3'd4,
    OP_DIVUW = 3'd5,
    OP_REMW  = 3'd6,
    OP_REMUW = 3'd7
  } divOpT;

  //////////////////////////////////////////////////////////////////////
  // Word operand width
  //////////////////////////////////////////////////////////////////////

  // Width of the operands and results of the W forms
  // Word results are sign-extended from the top bit of this field
  localparam int unsigned wordBits = 32;

endpackage

/* hdl/divCtrlPkg.sv */
// Divider control definitions
// State encoding of the divide sequencer, also decoded by the result stage

package divCtrlPkg;

  // Sequencer states
  // Idle waits for an accepted start
  // Busy runs the restoring steps
  // Done holds the result until the pipeline is no longer stalled
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_BUSY = 2'd1,
    DIV_DONE = 2'd2
  } divStateT;

endpackage

/* hdl/divOperandPrep.sv */
// Divider operand preparation
// Decodes the opcode, extends word operands and forms absolute values,
// sign corrections and the divide-by-zero flag

`timescale 1ns/1ps

module divOperandPrep import divOpPkg::*; #(
  parameter int unsigned xLen = 64
) (
  input  divOpT            op,
  input  logic [xLen-1:0]  srcA,
  input  logic [xLen-1:0]  srcB,
  output logic [xLen-1:0]  absDivisor,
  output logic [xLen-1:0]  initDividend,
  output logic             divByZero,
  output logic             wordOp,
  output logic             negQuot,
  output logic             negRem,
  output logic             wantRem
);

  logic            signedOp;
  logic            wordCode;
  logic [xLen-1:0] dividend;
  logic [xLen-1:0] divisor;
  logic            signDividend;
  logic            signDivisor;

  // Opcode decode into signed, word and remainder flags
  always_comb begin
    signedOp = 1'b0;
    wordCode = 1'b0;
    wantRem  = 1'b0;
    unique case (op)
      OP_DIV:   signedOp = 1'b1;
      OP_DIVU:  signedOp = 1'b0;
      OP_REM:   begin
        signedOp = 1'b1;
        wantRem  = 1'b1;
      end
      OP_REMU:  wantRem = 1'b1;
      OP_DIVW:  begin
        signedOp = 1'b1;
        wordCode = 1'b1;
      end
      OP_DIVUW: wordCode = 1'b1;
      OP_REMW:  begin
        signedOp = 1'b1;
        wordCode = 1'b1;
        wantRem  = 1'b1;
      end
      OP_REMUW: begin
        wordCode = 1'b1;
        wantRem  = 1'b1;
      end
      default:  signedOp = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Word operand placement
  //////////////////////////////////////////////////////////////////////

  if (xLen > wordBits) begin : gWordOps
    // The word dividend sits in the upper half so that half the steps
    // leave the 32-bit quotient in the low half of the shift register
    assign wordOp   = wordCode;
    assign dividend = wordCode ? {srcA[wordBits-1:0], {(xLen-wordBits){1'b0}}} : srcA;
    // Divisor is sign- or zero-extended to full width
    assign divisor  = wordCode ?
                      {{(xLen-wordBits){signedOp & srcB[wordBits-1]}}, srcB[wordBits-1:0]} :
                      srcB;
  end else begin : gNoWordOps
    // RV32 has no word forms
    assign wordOp   = 1'b0;
    assign dividend = srcA;
    assign divisor  = srcB;
  end

  // Signs only matter for the signed opcodes
  assign signDividend = signedOp & dividend[xLen-1];
  assign signDivisor  = signedOp & divisor[xLen-1];

  // Quotient is negative when the signs differ; remainder follows the dividend
  assign negQuot   = signDividend ^ signDivisor;
  assign negRem    = signDividend;
  assign divByZero = (divisor == '0);

  // Unsigned magnitudes for the restoring core
  // On divide by zero the raw dividend passes through so the remainder path returns it
  assign absDivisor   = signDivisor ? -divisor : divisor;
  assign initDividend = divByZero    ? srcA :
                        signDividend ? -dividend : dividend;

endmodule

/* hdl/divStep.sv */
// Restoring division step
// Shifts in one dividend bit, trial-subtracts the divisor and shifts the
// resulting quotient bit into the low end

`timescale 1ns/1ps

module divStep #(
  parameter int unsigned xLen = 64
) (
  input  logic [xLen-1:0] remIn,
  input  logic [xLen-1:0] quotIn,
  input  logic [xLen-1:0] divisor,
  output logic [xLen-1:0] remOut,
  output logic [xLen-1:0] quotOut
);

  // One extra bit keeps the shifted remainder exact for unsigned divisors
  logic [xLen:0] shiftedRem;
  logic [xLen:0] diff;
  logic          quotBit;

  // Bring the top dividend bit into the partial remainder
  assign shiftedRem = {remIn, quotIn[xLen-1]};
  assign diff       = shiftedRem - {1'b0, divisor};

  // No borrow means the divisor fit, so keep the difference
  assign quotBit = ~diff[xLen];
  assign remOut  = quotBit ? diff[xLen-1:0] : shiftedRem[xLen-1:0];
  assign quotOut = {quotIn[xLen-2:0], quotBit};

endmodule

/* hdl/divIterator.sv */
// Restoring divide iterator
// Partial-remainder and dividend/quotient registers around a chain of
// bitsPerCycle restoring steps

`timescale 1ns/1ps

module divIterator #(
  parameter int unsigned xLen         = 64,
  parameter int unsigned bitsPerCycle = 2
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            divStart,
  input  logic            busy,
  input  logic [xLen-1:0] initDividend,
  input  logic [xLen-1:0] absDivisor,
  output logic [xLen-1:0] rawQuot,
  output logic [xLen-1:0] rawRem
);

  logic [xLen-1:0] remReg;
  logic [xLen-1:0] quotReg;
  logic [xLen-1:0] divisorReg;
  // Element 0 is the register, element bitsPerCycle the value after one clock
  logic [xLen-1:0] remChain  [0:bitsPerCycle];
  logic [xLen-1:0] quotChain [0:bitsPerCycle];

  assign remChain[0]  = remReg;
  assign quotChain[0] = quotReg;

  // One step per quotient bit produced in a cycle
  for (genvar i = 0; i < bitsPerCycle; i++) begin : gSteps
    divStep #(
      .xLen (xLen)
    ) u_divStep (
      .remIn   (remChain[i]),
      .quotIn  (quotChain[i]),
      .divisor (divisorReg),
      .remOut  (remChain[i+1]),
      .quotOut (quotChain[i+1])
    );
  end

  // Load on the accepting edge, then advance on every busy edge
  // A zero divisor keeps the dividend in the quotient register for the remainder
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      remReg     <= '0;
      quotReg    <= '0;
      divisorReg <= '0;
    end else if (divStart) begin
      remReg     <= '0;
      quotReg    <= initDividend;
      divisorReg <= absDivisor;
    end else if (busy && (divisorReg != '0)) begin
      remReg  <= remChain[bitsPerCycle];
      quotReg <= quotChain[bitsPerCycle];
    end
  end

  assign rawQuot = quotReg;
  assign rawRem  = remReg;

endmodule

/* hdl/divSequencer.sv */
// Divide sequencer
// Accepts a start, counts the restoring steps and holds the done state
// while the pipeline is stalled

`timescale 1ns/1ps

module divSequencer import divCtrlPkg::*; #(
  parameter int unsigned xLen         = 64,
  parameter int unsigned bitsPerCycle = 2
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     start,
  input  logic     stall,
  input  logic     flush,
  input  logic     divByZero,
  input  logic     wordOp,
  output logic     divStart,
  output logic     busy,
  output divStateT divState
);

  // Full ops need xLen/bitsPerCycle steps, word ops half as many
  localparam int unsigned nFull    = xLen / bitsPerCycle;
  localparam int unsigned nWord    = nFull / 2;
  localparam int unsigned stepBits = $clog2(nFull) + 1;

  localparam logic [stepBits-1:0] fullSteps = stepBits'(nFull);
  localparam logic [stepBits-1:0] wordSteps = stepBits'(nWord);

  divStateT            state;
  logic [stepBits-1:0] stepCount;
  logic [stepBits-1:0] stepTarget;
  logic                wordReg;
  logic                zeroReg;

  // Accept only from idle and only when the pipeline can move
  assign divStart = start & (state == DIV_IDLE) & ~stall;
  // Busy already covers the accepting cycle so the iterator loads
  assign busy     = (state == DIV_BUSY) | divStart;
  assign divState = state;

  // Divide by zero needs no iterations, so it ends after one busy cycle
  assign stepTarget = zeroReg ? stepBits'(1) :
                      wordReg ? wordSteps : fullSteps;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= DIV_IDLE;
      stepCount <= '0;
      wordReg   <= 1'b0;
      zeroReg   <= 1'b0;
    end else if (flush) begin
      // A trap abandons whatever is in flight
      state <= DIV_IDLE;
    end else begin
      unique case (state)
        DIV_IDLE: begin
          if (divStart) begin
            stepCount <= stepBits'(1);
            wordReg   <= wordOp;
            zeroReg   <= divByZero;
            state     <= DIV_BUSY;
          end
        end
        DIV_BUSY: begin
          // The edge that performs the last step also ends the op
          if (stepCount == stepTarget) begin
            state <= DIV_DONE;
          end
          stepCount <= stepCount + 1'b1;
        end
        DIV_DONE: begin
          if (!stall) begin
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

endmodule

/* hdl/divResultSelect.sv */
// Divide result correction
// Captures the per-op control at start, restores signs, applies the
// RISC-V divide-by-zero results and sign-extends word results

`timescale 1ns/1ps

module divResultSelect import divOpPkg::*, divCtrlPkg::*; #(
  parameter int unsigned xLen = 64
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            divStart,
  input  divStateT        divState,
  input  logic            divByZero,
  input  logic            negQuot,
  input  logic            negRem,
  input  logic            wantRem,
  input  logic            wordOp,
  input  logic [xLen-1:0] rawQuot,
  input  logic [xLen-1:0] rawRem,
  output logic            done,
  output logic [xLen-1:0] result
);

  logic            divByZeroReg;
  logic            negQuotReg;
  logic            negRemReg;
  logic            wantRemReg;
  logic            wordReg;
  logic [xLen-1:0] quotFixed;
  logic [xLen-1:0] remFixed;
  logic [xLen-1:0] selected;

  // Control is frozen at the accepting edge so operands may change afterwards
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      divByZeroReg <= 1'b0;
      negQuotReg   <= 1'b0;
      negRemReg    <= 1'b0;
      wantRemReg   <= 1'b0;
      wordReg      <= 1'b0;
    end else if (divStart) begin
      divByZeroReg <= divByZero;
      negQuotReg   <= negQuot;
      negRemReg    <= negRem;
      wantRemReg   <= wantRem;
      wordReg      <= wordOp;
    end
  end

  // Divide by zero gives all ones, and the dividend is still in the quotient register
  assign quotFixed = divByZeroReg ? '1      : negQuotReg ? -rawQuot : rawQuot;
  assign remFixed  = divByZeroReg ? rawQuot : negRemReg  ? -rawRem  : rawRem;
  assign selected  = wantRemReg ? remFixed : quotFixed;

  if (xLen > wordBits) begin : gWordExt
    // Word results are sign-extended from bit 31
    assign result = wordReg ?
                    {{(xLen-wordBits){selected[wordBits-1]}}, selected[wordBits-1:0]} :
                    selected;
  end else begin : gNoWordExt
    assign result = selected;
  end

  assign done = (divState == DIV_DONE);

endmodule

/* hdl/intDivUnit.sv */
// Iterative restoring integer divider
// Executes the RISC-V M-extension divide and remainder instructions,
// including the word forms on RV64

`timescale 1ns/1ps

module intDivUnit import divOpPkg::*, divCtrlPkg::*; #(
  parameter int unsigned xLen         = 64,
  parameter int unsigned bitsPerCycle = 2
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            start,
  input  divOpT           op,
  input  logic [xLen-1:0] srcA,
  input  logic [xLen-1:0] srcB,
  input  logic            stall,
  input  logic            flush,
  output logic            busy,
  output logic            done,
  output logic [xLen-1:0] result
);

  // Prepared operands and per-op flags
  logic [xLen-1:0] absDivisor;
  logic [xLen-1:0] initDividend;
  logic            divByZero;
  logic            wordOp;
  logic            negQuot;
  logic            negRem;
  logic            wantRem;

  // Sequencing and raw iterator results
  logic            divStart;
  divStateT        divState;
  logic [xLen-1:0] rawQuot;
  logic [xLen-1:0] rawRem;

  //////////////////////////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////////////////////////

  divOperandPrep #(
    .xLen (xLen)
  ) u_operandPrep (
    .op           (op),
    .srcA         (srcA),
    .srcB         (srcB),
    .absDivisor   (absDivisor),
    .initDividend (initDividend),
    .divByZero    (divByZero),
    .wordOp       (wordOp),
    .negQuot      (negQuot),
    .negRem       (negRem),
    .wantRem      (wantRem)
  );

  //////////////////////////////////////////////////////////////////////
  // Control and iteration
  //////////////////////////////////////////////////////////////////////

  divSequencer #(
    .xLen         (xLen),
    .bitsPerCycle (bitsPerCycle)
  ) u_sequencer (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .stall     (stall),
    .flush     (flush),
    .divByZero (divByZero),
    .wordOp    (wordOp),
    .divStart  (divStart),
    .busy      (busy),
    .divState  (divState)
  );

  divIterator #(
    .xLen         (xLen),
    .bitsPerCycle (bitsPerCycle)
  ) u_iterator (
    .clk          (clk),
    .rstN         (rstN),
    .divStart     (divStart),
    .busy         (busy),
    .initDividend (initDividend),
    .absDivisor   (absDivisor),
    .rawQuot      (rawQuot),
    .rawRem       (rawRem)
  );

  // Sign correction and result selection
  divResultSelect #(
    .xLen (xLen)
  ) u_resultSelect (
    .clk       (clk),
    .rstN      (rstN),
    .divStart  (divStart),
    .divState  (divState),
    .divByZero (divByZero),
    .negQuot   (negQuot),
    .negRem    (negRem),
    .wantRem   (wantRem),
    .wordOp    (wordOp),
    .rawQuot   (rawQuot),
    .rawRem    (rawRem),
    .done      (done),
    .result    (result)
  );

endmodule

/* sim/divRefModel.svh */
// Golden model of the RISC-V M-extension divide and remainder instructions
// Follows the ISA rules for divide by zero, signed overflow and the W forms

`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// Full-width RV64 divide or remainder
function automatic logic [63:0] fullWidthOp(input logic isSigned, input logic isRem,
                                            input logic [63:0] a, input logic [63:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  sa = a;
  sb = b;
  // Divide by zero returns all ones, remainder returns the dividend
  if (b == 64'd0) return isRem ? a : '1;
  // Most negative value over minus one overflows back to itself
  if (isSigned && a == {1'b1, 63'd0} && b == '1) return isRem ? 64'd0 : a;
  // SV division truncates toward zero, as RISC-V does
  if (isSigned) return isRem ? sa % sb : sa / sb;
  return isRem ? a % b : a / b;
endfunction

// 32-bit divide or remainder used by the W forms
function automatic logic [31:0] wordWidthOp(input logic isSigned, input logic isRem,
                                            input logic [31:0] a, input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  sa = a;
  sb = b;
  if (b == 32'd0) return isRem ? a : '1;
  if (isSigned && a == 32'h8000_0000 && b == '1) return isRem ? 32'd0 : a;
  if (isSigned) return isRem ? sa % sb : sa / sb;
  return isRem ? a % b : a / b;
endfunction

// Architectural result of one divide instruction on RV64
function automatic logic [63:0] goldenResult(input divOpT op, input logic [63:0] a,
                                             input logic [63:0] b);
  logic        isSigned;
  logic        isRem;
  logic        isWord;
  logic [31:0] wordRes;
  isSigned = (op == OP_DIV) || (op == OP_REM) || (op == OP_DIVW) || (op == OP_REMW);
  isRem    = (op == OP_REM) || (op == OP_REMU) || (op == OP_REMW) || (op == OP_REMUW);
  isWord   = (op == OP_DIVW) || (op == OP_DIVUW) || (op == OP_REMW) || (op == OP_REMUW);
  if (!isWord) return fullWidthOp(isSigned, isRem, a, b);
  // W forms ignore the upper operand bits and sign-extend the 32-bit result
  wordRes = wordWidthOp(isSigned, isRem, a[31:0], b[31:0]);
  return {{32{wordRes[31]}}, wordRes};
endfunction

`endif

/* sim/intDivUnitTb.sv */
// Testbench for the iterative integer divider
// Random and directed divide ops checked against a golden model, plus
// latency, stall, flush and reset behaviour

`timescale 1ns/1ps

module intDivUnitTb import divOpPkg::*; ();

  localparam int unsigned xLen         = 64;
  localparam int unsigned bitsPerCycle = 2;
  localparam int unsigned nFull        = xLen / bitsPerCycle;
  localparam int unsigned nWord        = nFull / 2;
  localparam time         clkPeriod    = 100;
  localparam int          resetCycles  = 16;
  localparam int          numRandom    = 200;
  localparam int          numWord      = 64;
  // Directed, stall and flush runs all fit inside this many op slots
  localparam int          numOther     = 24;
  localparam int          watchdogCycles =
    (numRandom + numWord + numOther) * (nFull + 4) + resetCycles + 40;

  logic            clk;
  logic            rstN;
  logic            start;
  divOpT           op;
  logic [xLen-1:0] srcA;
  logic [xLen-1:0] srcB;
  logic            stall;
  logic            flush;
  logic            busy;
  logic            done;
  logic [xLen-1:0] result;

  int              checks;
  int              valueErrors;
  int              otherErrors;
  // Values seen at the previous falling edge, for the hold monitor
  logic            prevDone;
  logic            prevStall;
  logic            prevFlush;
  logic [xLen-1:0] prevResult;

  `include "divRefModel.svh"

  intDivUnit u_intDivUnit (
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .op     (op),
    .srcA   (srcA),
    .srcB   (srcB),
    .stall  (stall),
    .flush  (flush),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [xLen-1:0] expected,
                            input logic [xLen-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic printCounts();
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, valueErrors, otherErrors);
  endtask

  // Steps the unit needs, straight from the latency rules
  function automatic int stepsFor(input divOpT opIn, input logic [xLen-1:0] b);
    logic isWord;
    isWord = (opIn == OP_DIVW) || (opIn == OP_DIVUW) || (opIn == OP_REMW) ||
             (opIn == OP_REMUW);
    if (isWord ? (b[31:0] == 32'd0) : (b == '0)) return 1;
    return isWord ? nWord : nFull;
  endfunction

  // Random operand with a bias toward corner values of both widths
  function automatic logic [xLen-1:0] pickOperand();
    logic [xLen-1:0] value;
    value = {$urandom, $urandom};
    case ($urandom % 16)
      0:       value = '0;
      1:       value = 64'd1;
      2:       value = '1;
      3:       value = {1'b1, 63'd0};
      4:       value = {1'b0, {63{1'b1}}};
      5:       value[31:0] = 32'h8000_0000;
      6:       value[31:0] = '1;
      7:       value = value % 256;
      8, 9:    value = value >> ($urandom % 64);
      default: value = value;
    endcase
    return value;
  endfunction

  // Concurrent checks, sampled mid-cycle where every output is settled
  always @(negedge clk) begin
    if (rstN) begin
      assert (!(busy && done)) else begin
        $display("busy and done were high together at %0t", $time);
        otherErrors++;
      end
      // An edge with stall high and no flush must keep a finished result
      if (prevDone && prevStall && !prevFlush) begin
        assert (done && result === prevResult) else begin
          $display("CHECK FAILED held result: expected %h, actual %h", prevResult, result);
          valueErrors++;
        end
      end
    end else begin
      assert (!busy && !done) else begin
        $display("busy or done was high during reset at %0t", $time);
        otherErrors++;
      end
    end
    prevDone   = done;
    prevStall  = stall;
    prevFlush  = flush;
    prevResult = result;
  end

  //////////////////////////////////////////////////////////////////////
  // Operation runner
  //////////////////////////////////////////////////////////////////////

  // Runs one op; holdCycles > 0 keeps stall and start high through the op
  task automatic runOp(input divOpT opIn, input logic [xLen-1:0] a,
                       input logic [xLen-1:0] b, input logic [xLen-1:0] expected,
                       input int holdCycles);
    int edges;
    int wantEdges;
    wantEdges = stepsFor(opIn, b);
    @(posedge clk);
    #10;
    start = 1'b1;
    op    = opIn;
    srcA  = a;
    srcB  = b;
    @(negedge clk);
    checkValue("busy", 1'b1, busy);
    @(posedge clk);
    #10;
    // Inputs are free to change once the op is accepted
    start = (holdCycles > 0);
    stall = (holdCycles > 0);
    op    = divOpT'($urandom % 8);
    srcA  = {$urandom, $urandom};
    srcB  = {$urandom, $urandom};
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!done && edges <= wantEdges + 4);
    if (!done) begin
      $display("done did not rise within %0d cycles for opcode %0d", edges, opIn);
      otherErrors++;
    end else begin
      checkValue("doneLatency", wantEdges, edges);
      checkValue("result", expected, result);
    end
    if (holdCycles > 0) begin
      repeat (holdCycles) begin
        @(negedge clk);
        checkValue("done", 1'b1, done);
        checkValue("result", expected, result);
      end
      @(posedge clk);
      #10;
      start = 1'b0;
      stall = 1'b0;
      // The first unstalled edge returns the unit to idle
      @(negedge clk);
      @(negedge clk);
      checkValue("done", 1'b0, done);
      checkValue("busy", 1'b0, busy);
    end
  endtask

  // Starts a division and flushes it part way through
  task automatic flushMidOp();
    @(posedge clk);
    #10;
    start = 1'b1;
    op    = OP_DIV;
    srcA  = {$urandom, $urandom};
    srcB  = {$urandom, $urandom} | 64'd1;
    @(posedge clk);
    #10;
    start = 1'b0;
    repeat (5) @(posedge clk);
    #10;
    flush = 1'b1;
    @(posedge clk);
    #10;
    flush = 1'b0;
    @(negedge clk);
    checkValue("busy", 1'b0, busy);
    // The abandoned op must never complete
    repeat (nFull + 4) begin
      @(negedge clk);
      checkValue("done", 1'b0, done);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    divOpT           opSel;
    logic [xLen-1:0] a;
    logic [xLen-1:0] b;
    void'($urandom(24990));
    checks      = 0;
    valueErrors = 0;
    otherErrors = 0;
    prevDone    = 1'b0;
    prevStall   = 1'b0;
    prevFlush   = 1'b0;
    prevResult  = '0;
    rstN  = 1'b0;
    start = 1'b0;
    op    = OP_DIV;
    srcA  = '0;
    srcB  = '0;
    stall = 1'b0;
    flush = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #10;
    rstN = 1'b1;
    @(negedge clk);
    checkValue("busy", 1'b0, busy);
    checkValue("done", 1'b0, done);

    // Divide by zero, full and word forms with junk in the upper bits
    runOp(OP_DIV, 64'd100, 64'd0, '1, 0);
    runOp(OP_REM, 64'd100, 64'd0, 64'd100, 0);
    runOp(OP_REMU, 64'hdead_beef_0123_4567, '0, 64'hdead_beef_0123_4567, 0);
    runOp(OP_DIVW, 64'h1234_5678_8765_4321, 64'hffff_ffff_0000_0000, '1, 0);
    runOp(OP_REMW, 64'h1234_5678_8765_4321, 64'hffff_ffff_0000_0000,
          64'hffff_ffff_8765_4321, 0);
    runOp(OP_REMUW, 64'h0000_0001_1234_5678, 64'h5_0000_0000, 64'h1234_5678, 0);
    // Signed overflow
    runOp(OP_DIV, {1'b1, 63'd0}, '1, {1'b1, 63'd0}, 0);
    runOp(OP_REM, {1'b1, 63'd0}, '1, 64'd0, 0);
    runOp(OP_DIVW, 64'h8000_0000, 64'hffff_ffff, 64'hffff_ffff_8000_0000, 0);
    runOp(OP_REMW, 64'h8000_0000, 64'hffff_ffff, 64'd0, 0);
    // Truncation toward zero and remainder sign
    runOp(OP_DIV, 64'hffff_ffff_ffff_fff9, 64'd2, 64'hffff_ffff_ffff_fffd, 0);
    runOp(OP_REM, 64'hffff_ffff_ffff_fff9, 64'd2, '1, 0);
    runOp(OP_DIV, 64'd7, 64'hffff_ffff_ffff_fffe, 64'hffff_ffff_ffff_fffd, 0);
    runOp(OP_REM, 64'd7, 64'hffff_ffff_ffff_fffe, 64'd1, 0);

    for (int i = 0; i < numRandom; i++) begin
      opSel = divOpT'($urandom % 4);
      a     = pickOperand();
      b     = pickOperand();
      runOp(opSel, a, b, goldenResult(opSel, a, b), 0);
    end
    for (int i = 0; i < numWord; i++) begin
      opSel = divOpT'(4 + $urandom % 4);
      a     = pickOperand();
      b     = pickOperand();
      runOp(opSel, a, b, goldenResult(opSel, a, b), 0);
    end

    // Back-pressure on a long op and on a one-cycle divide by zero
    a = {$urandom, $urandom};
    b = {$urandom, $urandom} | 64'd1;
    runOp(OP_REMU, a, b, goldenResult(OP_REMU, a, b), 6);
    runOp(OP_DIVU, a, 64'd0, '1, 4);

    flushMidOp();
    a = pickOperand();
    b = pickOperand();
    runOp(OP_DIV, a, b, goldenResult(OP_DIV, a, b), 0);

    printCounts();
    if (valueErrors + otherErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the number of ops and the step count
  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
    printCounts();
    $display("Done: errors found");
    $finish;
  end

endmodule

/* project.f */
+incdir+sim
hdl/divOpPkg.sv
hdl/divCtrlPkg.sv
hdl/divOperandPrep.sv
hdl/divStep.sv
hdl/divIterator.sv
hdl/divSequencer.sv
hdl/divResultSelect.sv
hdl/intDivUnit.sv
sim/intDivUnitTb.sv

/* Bender.yml */
package:
  name: int_div_unit

sources:
  # Packages first, then the blocks, then the top level
  - hdl/divOpPkg.sv
  - hdl/divCtrlPkg.sv
  - hdl/divOperandPrep.sv
  - hdl/divStep.sv
  - hdl/divIterator.sv
  - hdl/divSequencer.sv
  - hdl/divResultSelect.sv
  - hdl/intDivUnit.sv

  # Testbench, which includes the golden model from sim
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/intDivUnitTb.sv
